// ==== source/tgfx_cfg.svh ====
// Shared depths, download indexes and signature words; include in RTL and testbench
`ifndef TGFX_CFG_SVH
`define TGFX_CFG_SVH

// ==========================================================================
// Backup RAM image
// ==========================================================================
`define TGFX_BK_SECTORS 16            // 512-byte sectors per save image

// Default save header written by the format command
`define TGFX_BK_HDR0 16'h5548
`define TGFX_BK_HDR1 16'h4D42
`define TGFX_BK_HDR2 16'h8800
`define TGFX_BK_HDR3 16'h8010

// ==========================================================================
// Download indexes and Populous signature
// ==========================================================================
`define TGFX_CODE_INDEX 8'hFF         // Cheat file
`define TGFX_SGX_INDEX  5'd2          // Low index bits of a SuperGrafx image

`define TGFX_POP_BASE0 24'h1F20       // Signature window, unheadered image
`define TGFX_POP_BASE1 24'h2120       // Signature window, headered image
`define TGFX_POP_W0    16'h4F50       // Offset 6
`define TGFX_POP_W1    16'h5550       // Offset 8
`define TGFX_POP_W2    16'h4F4C       // Offset 10
`define TGFX_POP_W3    16'h5355       // Offset 12

`endif

// ==== source/tgfx_pkg.sv ====
// Shared vector types, bundles and FSM state of the host glue; import where a type is used
package tgfx_pkg;

	typedef logic [23:0] rom_addr_t;   // ROM byte address
	typedef logic [15:0] rom_word_t;   // Download and ROM data word
	typedef logic [10:0] bram_addr_t;  // Core backup RAM byte address
	typedef logic [7:0]  bram_byte_t;
	typedef logic [31:0] sd_lba_t;

	// Download port from the host
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		rom_word_t   data;
	} ioctl_t;

	// Write request to both ROM memories
	typedef struct packed {
		logic      req;                // Toggles once per word
		rom_addr_t addr;
		rom_word_t data;
	} rom_wr_t;

	typedef struct packed {
		logic        strobe;           // One cycle, code complete
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	// Backup RAM menu levels
	typedef struct packed {
		logic load;
		logic save;
		logic autosave;
		logic format;
		logic osd_open;
		logic swap;                    // ROM byte bit reversal
	} bk_ctrl_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_e;

endpackage

// ==== source/rom_loader.sv ====
// Cartridge download sequencer; feeds words to both ROM memories and flags SGX and Populous
`include "tgfx_cfg.svh"

module rom_loader import tgfx_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst,
	input  ioctl_t    ioctl,
	input  logic      swap,
	input  logic      dd_wrack,
	input  logic      sd_wrack,
	output logic      ioctl_wait,
	output rom_wr_t   rom_wr,
	output logic      cart_download,
	output logic      sgx,
	output logic[1:0] rom_pop
);

	localparam rom_addr_t POP_BASE0 = `TGFX_POP_BASE0;
	localparam rom_addr_t POP_BASE1 = `TGFX_POP_BASE1;

	logic      old_dl;
	logic      req_q;
	rom_addr_t addr_q;
	rom_word_t data_q;
	rom_word_t wr_data;
	logic      dl_rise;
	logic      accept;
	logic      done;
	logic      in_window;
	logic      sig_bad;

	assign cart_download = ioctl.download && (ioctl.index != `TGFX_CODE_INDEX);
	assign dl_rise       = cart_download && !old_dl;
	assign accept        = ioctl.wr && cart_download;
	assign done          = (req_q == dd_wrack) && (req_q == sd_wrack);

	// Reverse bit order inside each byte
	always_comb begin
		wr_data = ioctl.data;
		if (swap) begin
			for (int i = 0; i < 8; i++) begin
				wr_data[i]     = ioctl.data[7 - i];
				wr_data[8 + i] = ioctl.data[15 - i];
			end
		end
	end

	assign in_window = (addr_q[23:4] == POP_BASE0[23:4]) || (addr_q[23:4] == POP_BASE1[23:4]);

	always_comb begin
		case (addr_q[3:0])
			4'd6:    sig_bad = (wr_data != `TGFX_POP_W0);
			4'd8:    sig_bad = (wr_data != `TGFX_POP_W1);
			4'd10:   sig_bad = (wr_data != `TGFX_POP_W2);
			4'd12:   sig_bad = (wr_data != `TGFX_POP_W3);
			default: sig_bad = 1'b0;
		endcase
	end

	// ==========================================================================
	// Write handshake
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_dl     <= 1'b0;
			ioctl_wait <= 1'b0;
			req_q      <= 1'b0;
			addr_q     <= '0;
			sgx        <= 1'b0;
			rom_pop    <= 2'b00;
		end else begin
			old_dl <= cart_download;
			if (dl_rise) begin
				addr_q  <= '0;
				rom_pop <= 2'b11;
				sgx     <= (ioctl.index[4:0] == `TGFX_SGX_INDEX);
			end else if (accept) begin
				ioctl_wait <= 1'b1;
				req_q      <= ~req_q;
				if (in_window && sig_bad)
					rom_pop[addr_q[13]] <= 1'b0;  // Bit 13 tells the windows apart
			end else if (ioctl_wait && done) begin
				ioctl_wait <= 1'b0;           // Both memories took the word
				addr_q     <= addr_q + 24'd2;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept)
			data_q <= wr_data;
	end

	assign rom_wr = '{req: req_q, addr: addr_q, data: data_q};

	// Host must hold its next word until the memories have answered
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait |-> !ioctl.wr);

endmodule

// ==== source/cheat_loader.sv ====
// Cheat file decoder; collects eight words into one strobed code for the core
`include "tgfx_cfg.svh"

module cheat_loader import tgfx_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst,
	input  ioctl_t   ioctl,
	output gg_code_t gg_code
);

	logic        code_wr;
	logic        strobe_q;
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] cmp_q;
	logic [31:0] rep_q;

	assign code_wr = ioctl.download && ioctl.wr && (ioctl.index == `TGFX_CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (rst)
			strobe_q <= 1'b0;
		else
			strobe_q <= code_wr && (ioctl.addr[3:0] == 4'd14);  // Last word of a code
	end

	// Low half first for every field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:    flags_q[15:0]  <= ioctl.data;
				4'd2:    flags_q[31:16] <= ioctl.data;
				4'd4:    addr_q[15:0]   <= ioctl.data;
				4'd6:    addr_q[31:16]  <= ioctl.data;
				4'd8:    cmp_q[15:0]    <= ioctl.data;
				4'd10:   cmp_q[31:16]   <= ioctl.data;
				4'd12:   rep_q[15:0]    <= ioctl.data;
				4'd14:   rep_q[31:16]   <= ioctl.data;
				default: ;
			endcase
		end
	end

	assign gg_code = '{strobe: strobe_q, flags: flags_q, addr: addr_q,
		compare: cmp_q, replace: rep_q};

endmodule

// ==== source/backup_ram.sv ====
// Save memory in two byte lanes; core byte port, SD word port and format header writer
`include "tgfx_cfg.svh"

module backup_ram import tgfx_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  bram_addr_t bram_addr,
	input  bram_byte_t bram_data,
	input  logic       bram_wr,
	output bram_byte_t bram_q,
	input  logic [3:0] sd_lba_lo,
	input  logic [7:0] sd_buff_addr,
	input  rom_word_t  sd_buff_dout,
	input  logic       sd_buff_wr,
	input  logic       sd_ack,
	output rom_word_t  sd_buff_din,
	input  logic       format
);

	localparam int WORDS = `TGFX_BK_SECTORS * 256;

	logic [3:0]  fmt_cnt;        // Bit 3 set when idle
	logic        old_format;
	logic        fmt_busy;
	rom_word_t   hdr_word;
	logic [11:0] core_addr;
	logic [11:0] b_addr;
	rom_word_t   b_data;
	logic        b_we;
	logic        sel_q;
	bram_byte_t  core_q [2];
	bram_byte_t  sd_q [2];

	// ==========================================================================
	// Format header writer
	// ==========================================================================
	assign fmt_busy = !fmt_cnt[3];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_format <= 1'b0;
			fmt_cnt    <= 4'h8;
		end else begin
			old_format <= format;
			if (format && !old_format)
				fmt_cnt <= 4'h0;
			else if (fmt_busy)
				fmt_cnt <= fmt_cnt + 4'd1;  // Writes on odd counts
		end
	end

	always_comb begin
		case (fmt_cnt[2:1])
			2'd0:    hdr_word = `TGFX_BK_HDR0;
			2'd1:    hdr_word = `TGFX_BK_HDR1;
			2'd2:    hdr_word = `TGFX_BK_HDR2;
			default: hdr_word = `TGFX_BK_HDR3;
		endcase
	end

	// Port B belongs to the header writer while it runs
	assign core_addr = {2'b00, bram_addr[10:1]};
	assign b_addr    = fmt_busy ? {10'd0, fmt_cnt[2:1]} : {sd_lba_lo, sd_buff_addr};
	assign b_data    = fmt_busy ? hdr_word : sd_buff_dout;
	assign b_we      = fmt_busy ? fmt_cnt[0] : (sd_buff_wr && sd_ack);

	// ==========================================================================
	// Byte lanes, even bytes in lane 0
	// ==========================================================================
	for (genvar l = 0; l < 2; l++) begin : g_lane
		bram_byte_t mem [WORDS];
		logic       core_we;

		assign core_we = bram_wr && (bram_addr[0] == 1'(l));

		always_ff @(posedge clk_sys) begin
			if (core_we)
				mem[core_addr] <= bram_data;
			if (b_we)
				mem[b_addr] <= b_data[l*8 +: 8];
			core_q[l] <= mem[core_addr];
			sd_q[l]   <= mem[b_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		sel_q <= bram_addr[0];        // Lane select follows the read data
	end

	assign bram_q      = sel_q ? core_q[1] : core_q[0];
	assign sd_buff_din = {sd_q[1], sd_q[0]};

endmodule

// ==== source/backup_sync.sv ====
// Save and load sequencer; moves backup RAM to and from the SD image, with autosave and LED
`include "tgfx_cfg.svh"

module backup_sync import tgfx_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  bk_ctrl_t    ctrl,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        bram_wr,
	input  logic        sd_ack,
	output sd_req_t     sd_req,
	output logic        busy,
	output logic        core_hold,
	output logic        led
);

	localparam sd_lba_t LAST_LBA = sd_lba_t'(`TGFX_BK_SECTORS - 1);

	bk_state_e state;
	sd_lba_t   lba_q;
	logic      rd_q;
	logic      wr_q;
	logic      ena;
	logic      pending;           // Core wrote since the last transfer
	logic      loading;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      old_dl;
	logic      save_req;
	logic      start;

	assign save_req = ctrl.save || (pending && ctrl.osd_open && ctrl.autosave);
	assign start    = ena && ((ctrl.load && !old_load) || (save_req && !old_save));

	// ==========================================================================
	// Enable and pending flags
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ena     <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (cart_download && !old_dl)
				ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				ena <= 1'b1;              // Save image arrives with the cartridge
			if (ena && !ctrl.osd_open && bram_wr)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// ==========================================================================
	// Sector walk
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= BK_IDLE;
			lba_q    <= '0;
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			loading  <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			old_dl   <= 1'b0;
		end else begin
			old_load <= ctrl.load;
			old_save <= save_req;
			old_ack  <= sd_ack;
			old_dl   <= cart_download;
			if (sd_ack && !old_ack) begin
				rd_q <= 1'b0;
				wr_q <= 1'b0;
			end
			case (state)
				BK_IDLE: begin
					if (start) begin
						state   <= BK_XFER;
						loading <= ctrl.load;
						lba_q   <= '0;
						rd_q    <= ctrl.load;
						wr_q    <= !ctrl.load;
					end
					if (old_dl && !cart_download && |img_size && ena) begin
						state   <= BK_XFER;   // Load after every download
						loading <= 1'b1;
						lba_q   <= '0;
						rd_q    <= 1'b1;
						wr_q    <= 1'b0;
					end
				end
				BK_XFER: begin
					if (old_ack && !sd_ack) begin
						if (lba_q == LAST_LBA) begin
							state   <= BK_IDLE;
							loading <= 1'b0;
						end else begin
							lba_q <= lba_q + 32'd1;
							rd_q  <= loading;
							wr_q  <= !loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assign sd_req    = '{lba: lba_q, rd: rd_q, wr: wr_q};
	assign busy      = (state == BK_XFER);
	assign core_hold = loading;
	assign led       = cart_download || busy || (ctrl.autosave && pending);

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (rst)
		!(sd_req.rd && sd_req.wr));

endmodule

// ==== source/tgfx_host_io.sv ====
// Host glue top level; joins ROM and cheat loaders with the backup RAM and its SD sequencer
module tgfx_host_io import tgfx_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  ioctl_t      ioctl,
	output logic        ioctl_wait,
	input  bk_ctrl_t    ctrl,
	// ROM memories
	input  logic        dd_wrack,
	input  logic        sd_wrack,
	output rom_wr_t     rom_wr,
	output logic        cart_download,
	output logic        sgx,
	output logic [1:0]  rom_pop,
	output gg_code_t    gg_code,
	// Core backup RAM port
	input  bram_addr_t  bram_addr,
	input  bram_byte_t  bram_data,
	input  logic        bram_wr,
	output bram_byte_t  bram_q,
	output logic        core_hold,
	// SD image
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	output sd_req_t     sd_req,
	input  logic        sd_ack,
	input  logic [7:0]  sd_buff_addr,
	input  rom_word_t   sd_buff_dout,
	input  logic        sd_buff_wr,
	output rom_word_t   sd_buff_din,
	output logic        busy,
	output logic        led
);

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ioctl         (ioctl),
		.swap          (ctrl.swap),
		.dd_wrack      (dd_wrack),
		.sd_wrack      (sd_wrack),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.cart_download (cart_download),
		.sgx           (sgx),
		.rom_pop       (rom_pop)
	);

	cheat_loader u_cheat_loader (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ioctl   (ioctl),
		.gg_code (gg_code)
	);

	backup_ram u_backup_ram (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.bram_addr    (bram_addr),
		.bram_data    (bram_data),
		.bram_wr      (bram_wr),
		.bram_q       (bram_q),
		.sd_lba_lo    (sd_req.lba[3:0]),  // Sector within the image
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din),
		.format       (ctrl.format)
	);

	backup_sync u_backup_sync (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ctrl          (ctrl),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bram_wr       (bram_wr),
		.sd_ack        (sd_ack),
		.sd_req        (sd_req),
		.busy          (busy),
		.core_hold     (core_hold),
		.led           (led)
	);

endmodule

// ==== tb/tb_tgfx_host_io.sv ====
// Directed testbench for the host glue; memory-ack and SD host models, one task per behavior
`include "tgfx_cfg.svh"

module tb_tgfx_host_io import tgfx_pkg::*; ();

	logic        clk_sys;
	logic        rst;
	ioctl_t      ioctl;
	logic        ioctl_wait;
	bk_ctrl_t    ctrl;
	logic        dd_wrack;
	logic        sd_wrack;
	rom_wr_t     rom_wr;
	logic        cart_download;
	logic        sgx;
	logic [1:0]  rom_pop;
	gg_code_t    gg_code;
	bram_addr_t  bram_addr;
	bram_byte_t  bram_data;
	logic        bram_wr;
	bram_byte_t  bram_q;
	logic        core_hold;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;
	sd_req_t     sd_req;
	logic        sd_ack;
	logic [7:0]  sd_buff_addr;
	rom_word_t   sd_buff_dout;
	logic        sd_buff_wr;
	rom_word_t   sd_buff_din;
	logic        busy;
	logic        led;

	int          strobe_count;
	logic        seen_req;
	rom_addr_t   cap_addr [$];
	rom_word_t   cap_data [$];
	sd_lba_t     sd_lbas [$];
	logic        sd_wrs [$];
	rom_word_t   save_img [4096];    // Words saved by the SD model

	tgfx_host_io u_tgfx_host_io (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==========================================================================
	// Reporting
	// ==========================================================================
	task automatic stop_failed();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			$display("** Error [%s] %s: expected %h, actual %h", test, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic timeout_error(string what);
		$display("Timed out waiting for %s", what);
		stop_failed();
	endtask

	// Byte-wise bit reversal, as the loader applies with swap
	function automatic rom_word_t reverse_bytes(rom_word_t w);
		rom_word_t r;
		for (int i = 0; i < 16; i++)
			r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
		return r;
	endfunction

	// Load image content for save word w
	function automatic rom_word_t load_pattern(int w);
		return 16'(w * 40503 + 4660);
	endfunction

	// ==========================================================================
	// Models
	// ==========================================================================
	initial begin : dd_ack_model
		forever begin
			@(negedge clk_sys);
			if (!rst && rom_wr.req !== dd_wrack) begin
				repeat ($urandom_range(4, 1)) @(negedge clk_sys);
				dd_wrack = rom_wr.req;
			end
		end
	end

	// Second memory answers on its own delay
	initial begin : sd_ack_model
		forever begin
			@(negedge clk_sys);
			if (!rst && rom_wr.req !== sd_wrack) begin
				repeat ($urandom_range(4, 1)) @(negedge clk_sys);
				sd_wrack = rom_wr.req;
			end
		end
	end

	initial begin : rom_capture
		forever begin
			@(negedge clk_sys);
			if (!rst && rom_wr.req !== seen_req) begin
				seen_req = rom_wr.req;
				cap_addr.push_back(rom_wr.addr);
				cap_data.push_back(rom_wr.data);
			end
			if (!rst && gg_code.strobe)
				strobe_count++;
		end
	end

	initial begin : sd_host_model
		sd_lba_t lba;
		logic    is_wr;
		int      idx;
		forever begin
			@(negedge clk_sys);
			if (!rst && (sd_req.rd || sd_req.wr)) begin
				lba   = sd_req.lba;
				is_wr = sd_req.wr;
				sd_lbas.push_back(lba);
				sd_wrs.push_back(is_wr);
				sd_ack = 1'b1;
				for (int a = 0; a < 256; a++) begin
					idx          = int'(lba[3:0]) * 256 + a;
					sd_buff_addr = 8'(a);
					sd_buff_wr   = !is_wr;
					sd_buff_dout = load_pattern(idx);
					@(negedge clk_sys);
					if (is_wr)
						save_img[idx] = sd_buff_din;  // One cycle read latency
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
		end
	end

	// ==========================================================================
	// Stimulus helpers
	// ==========================================================================
	task automatic start_download(logic [7:0] idx);
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl.download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic write_rom_word(string test, rom_word_t d);
		int n;
		@(negedge clk_sys);
		ioctl.wr   = 1'b1;
		ioctl.data = d;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		check_value(test, "ioctl_wait after write", 32'd1, 32'(ioctl_wait));
		n = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			n++;
			if (n > 50)
				timeout_error("ioctl_wait to fall");
		end
		check_value(test, "dd_wrack", 32'(rom_wr.req), 32'(dd_wrack));
		check_value(test, "sd_wrack", 32'(rom_wr.req), 32'(sd_wrack));
	endtask

	task automatic write_cheat_word(logic [3:0] offs, rom_word_t d);
		@(negedge clk_sys);
		ioctl.wr   = 1'b1;
		ioctl.addr = 25'(offs);
		ioctl.data = d;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
	endtask

	task automatic core_write(bram_addr_t a, bram_byte_t d);
		@(negedge clk_sys);
		bram_addr = a;
		bram_data = d;
		bram_wr   = 1'b1;
		@(negedge clk_sys);
		bram_wr = 1'b0;
	endtask

	// Writable image mounted during a short download enables save and load
	task automatic mount_image();
		start_download(8'h00);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		end_download();
	endtask

	task automatic wait_busy(logic level, string what);
		int n;
		n = 0;
		while (busy !== level) begin
			@(negedge clk_sys);
			n++;
			if (n > 20000)
				timeout_error(what);
		end
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================
	task automatic test_rom_write();
		rom_word_t words [8];
		rom_word_t exp;
		for (int pass = 0; pass < 2; pass++) begin
			ctrl.swap = 1'(pass);
			cap_addr.delete();
			cap_data.delete();
			start_download(8'h00);
			check_value("test_rom_write", "cart_download", 32'd1, 32'(cart_download));
			for (int i = 0; i < 8; i++) begin
				words[i] = 16'($urandom);
				write_rom_word("test_rom_write", words[i]);
			end
			end_download();
			check_value("test_rom_write", "sgx", 32'd0, 32'(sgx));
			check_value("test_rom_write", "word count", 32'd8, 32'(cap_addr.size()));
			for (int i = 0; i < 8; i++) begin
				exp = pass ? reverse_bytes(words[i]) : words[i];
				check_value("test_rom_write", "address", 32'(i * 2), 32'(cap_addr[i]));
				check_value("test_rom_write", "data", 32'(exp), 32'(cap_data[i]));
			end
		end
		ctrl.swap = 1'b0;
	endtask

	task automatic test_rom_detect();
		rom_word_t d;
		int        offs;
		cap_addr.delete();
		cap_data.delete();
		start_download(8'h02);
		for (int a = 0; a < 'h2130; a += 2) begin
			offs = a % 16;
			d    = 16'h0000;      // Wrong everywhere in the 0x1F20 window
			if (a >= `TGFX_POP_BASE1) begin
				case (offs)
					6:       d = `TGFX_POP_W0;
					8:       d = `TGFX_POP_W1;
					10:      d = `TGFX_POP_W2;
					12:      d = `TGFX_POP_W3;
					default: d = 16'h0000;
				endcase
			end
			write_rom_word("test_rom_detect", d);
		end
		check_value("test_rom_detect", "sgx", 32'd1, 32'(sgx));
		check_value("test_rom_detect", "rom_pop", 32'd2, 32'(rom_pop));
		end_download();
	endtask

	task automatic test_cheat();
		rom_word_t w [8];
		int        n;
		strobe_count = 0;
		start_download(`TGFX_CODE_INDEX);
		check_value("test_cheat", "cart_download", 32'd0, 32'(cart_download));
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($urandom);
			write_cheat_word(4'(i * 2), w[i]);
		end
		n = 0;
		while (strobe_count == 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 20)
				timeout_error("the cheat strobe");
		end
		repeat (4) @(negedge clk_sys);
		end_download();
		check_value("test_cheat", "strobe cycles", 32'd1, 32'(strobe_count));
		check_value("test_cheat", "flags", {w[1], w[0]}, gg_code.flags);
		check_value("test_cheat", "addr", {w[3], w[2]}, gg_code.addr);
		check_value("test_cheat", "compare", {w[5], w[4]}, gg_code.compare);
		check_value("test_cheat", "replace", {w[7], w[6]}, gg_code.replace);
	endtask

	task automatic save_image(string test);
		sd_lbas.delete();
		sd_wrs.delete();
		@(negedge clk_sys);
		ctrl.save = 1'b1;
		@(negedge clk_sys);
		ctrl.save = 1'b0;
		wait_busy(1'b1, "busy to rise on save");
		wait_busy(1'b0, "busy to fall after save");
		check_value(test, "sector count", `TGFX_BK_SECTORS, 32'(sd_lbas.size()));
		for (int i = 0; i < sd_lbas.size(); i++) begin
			check_value(test, "sector lba", 32'(i), sd_lbas[i]);
			check_value(test, "sector is write", 32'd1, 32'(sd_wrs[i]));
		end
	endtask

	task automatic test_format_save();
		mount_image();
		@(negedge clk_sys);
		ctrl.format = 1'b1;
		repeat (12) @(negedge clk_sys);
		ctrl.format = 1'b0;
		save_image("test_format_save");
		check_value("test_format_save", "header 0", `TGFX_BK_HDR0, 32'(save_img[0]));
		check_value("test_format_save", "header 1", `TGFX_BK_HDR1, 32'(save_img[1]));
		check_value("test_format_save", "header 2", `TGFX_BK_HDR2, 32'(save_img[2]));
		check_value("test_format_save", "header 3", `TGFX_BK_HDR3, 32'(save_img[3]));
		check_value("test_format_save", "led", 32'd0, 32'(led));
	endtask

	task automatic test_core_roundtrip();
		bram_addr_t a;
		rom_word_t  w;
		core_write(11'h124, 8'hA7);
		core_write(11'h125, 8'h5E);
		save_image("test_core_roundtrip");
		check_value("test_core_roundtrip", "packed word", 32'h5EA7, 32'(save_img['h92]));
		sd_lbas.delete();
		sd_wrs.delete();
		@(negedge clk_sys);
		ctrl.load = 1'b1;
		@(negedge clk_sys);
		ctrl.load = 1'b0;
		wait_busy(1'b1, "busy to rise on load");
		check_value("test_core_roundtrip", "core_hold in load", 32'd1, 32'(core_hold));
		wait_busy(1'b0, "busy to fall after load");
		check_value("test_core_roundtrip", "core_hold after load", 32'd0, 32'(core_hold));
		check_value("test_core_roundtrip", "load sector count", `TGFX_BK_SECTORS,
			32'(sd_lbas.size()));
		for (int i = 0; i < sd_lbas.size(); i++) begin
			check_value("test_core_roundtrip", "load lba", 32'(i), sd_lbas[i]);
			check_value("test_core_roundtrip", "sector is read", 32'd0, 32'(sd_wrs[i]));
		end
		for (int i = 0; i < 16; i++) begin
			a = 11'($urandom);
			w = load_pattern(int'(a[10:1]));
			@(negedge clk_sys);
			bram_addr = a;
			@(negedge clk_sys);
			check_value("test_core_roundtrip", "bram_q",
				32'(a[0] ? w[15:8] : w[7:0]), 32'(bram_q));
		end
	endtask

	task automatic test_autosave();
		int n;
		mount_image();
		ctrl.autosave = 1'b1;
		@(negedge clk_sys);
		check_value("test_autosave", "led before write", 32'd0, 32'(led));
		core_write(11'h010, 8'h3C);
		check_value("test_autosave", "led after write", 32'd1, 32'(led));
		sd_lbas.delete();
		sd_wrs.delete();
		ctrl.osd_open = 1'b1;
		n = 0;
		while (sd_wrs.size() == 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 50)
				timeout_error("the autosave request");
		end
		check_value("test_autosave", "request is write", 32'd1, 32'(sd_wrs[0]));
		wait_busy(1'b0, "busy to fall after autosave");
		ctrl.osd_open = 1'b0;
		ctrl.autosave = 1'b0;
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial begin
		void'($urandom(71));
		strobe_count = 0;
		seen_req     = 1'b0;
		rst          = 1'b1;
		ioctl        = '0;
		ctrl         = '0;
		dd_wrack     = 1'b0;
		sd_wrack     = 1'b0;
		bram_addr    = '0;
		bram_data    = '0;
		bram_wr      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'd0;         // Loads start from the menu only
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		repeat (10) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		test_rom_write();
		test_rom_detect();
		test_cheat();
		test_format_save();
		test_core_roundtrip();
		test_autosave();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+source
source/tgfx_pkg.sv
source/rom_loader.sv
source/cheat_loader.sv
source/backup_ram.sv
source/backup_sync.sv
source/tgfx_host_io.sv
tb/tb_tgfx_host_io.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_tgfx_host_io
FLIST     = flist.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
